//--- logic/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import gpuDecodePkg::*; #(
	parameter int numWarps = 8,
	parameter int numLanes = 2
) (
	input logic clk,
	input logic rstN,
	input fetchSlotT [numLanes-1:0] fetchIn,
	input logic issueValid,
	input logic [$clog2(numWarps)-1:0] issueWarp,
	output redirectT [numLanes-1:0] redirect,
	output simtEventT [numLanes-1:0] simtEvent,
	output decodedT issued,
	output logic issuedValid,
	output logic [numWarps-1:0] occupied
);

	fetchSlotT [numLanes-1:0] latched;
	decodedT [numLanes-1:0] decoded;

	fetchLatch #(
		.numLanes(numLanes)
	) fetchLatch_inst (
		.clk(clk),
		.rstN(rstN),
		.fetchIn(fetchIn),
		.latched(latched)
	);

	// One combinational decoder per fetch slot
	for (genvar lane = 0; lane < numLanes; lane++) begin : gLane
		laneDecoder laneDecoder_inst (
			.slot(latched[lane]),
			.dec(decoded[lane])
		);
	end

	pcRedirect #(
		.numLanes(numLanes)
	) pcRedirect_inst (
		.clk(clk),
		.rstN(rstN),
		.dec(decoded),
		.redirect(redirect),
		.simtEvent(simtEvent)
	);

	instrBuffer #(
		.numWarps(numWarps),
		.numLanes(numLanes)
	) instrBuffer_inst (
		.clk(clk),
		.rstN(rstN),
		.dec(decoded),
		.issueValid(issueValid),
		.issueWarp(issueWarp),
		.issued(issued),
		.issuedValid(issuedValid),
		.occupied(occupied)
	);

endmodule

//--- logic/fetchLatch.sv
`timescale 1ns/1ps

module fetchLatch import gpuDecodePkg::*; #(
	parameter int numLanes = 2
) (
	input logic clk,
	input logic rstN,
	input fetchSlotT [numLanes-1:0] fetchIn,
	output fetchSlotT [numLanes-1:0] latched
);

	// Warp masks carry the valid state
	always_ff @(posedge clk) begin
		for (int l = 0; l < numLanes; l++) begin
			if (!rstN) begin
				latched[l].warpMask <= '0;
			end else begin
				latched[l].warpMask <= fetchIn[l].warpMask;
			end
			latched[l].pcPlus4 <= fetchIn[l].pcPlus4;
			latched[l].instr <= fetchIn[l].instr;
		end
	end

	// A fetched warp must reach decode as exactly one warp
	for (genvar l = 0; l < numLanes; l++) begin : gCheck
		aOneHotMask: assert property (
			@(posedge clk) disable iff (!rstN)
			fetchIn[l].warpMask != '0 |=> $onehot(latched[l].warpMask)
		) else $error("fetchLatch lane %0d: warp mask not one-hot", l);
	end

endmodule

//--- logic/gpuDecodePkg.sv
package gpuDecodePkg;

	localparam int warpCnt = 8; // Width of every warp mask
	localparam int dotSBit = 4; // Opcode bit that marks a .S twin

	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluMul = 4'd2,
		aluAnd = 4'd3,
		aluOr = 4'd4,
		aluXor = 4'd5,
		aluShr = 4'd6,
		aluShl = 4'd7
	} aluOpT;

	// Base opcodes, bit 4 clear
	localparam logic [5:0] opInt = 6'b000000;
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opAndi = 6'b001100;
	localparam logic [5:0] opOri = 6'b001101;
	localparam logic [5:0] opXori = 6'b001110;
	localparam logic [5:0] opLd = 6'b100011;
	localparam logic [5:0] opLds = 6'b100111; // Shared memory load
	localparam logic [5:0] opSw = 6'b101011;
	localparam logic [5:0] opSws = 6'b101111; // Shared memory store
	localparam logic [5:0] opBeq = 6'b000100;
	localparam logic [5:0] opBlt = 6'b000111;
	localparam logic [5:0] opJ = 6'b000010;
	localparam logic [5:0] opCall = 6'b000011;
	localparam logic [5:0] opRet = 6'b000110;
	localparam logic [5:0] opExit = 6'b100001;

	localparam logic [5:0] fnAdd = 6'b100000;
	localparam logic [5:0] fnSub = 6'b100010;
	localparam logic [5:0] fnMul = 6'b011000;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnXor = 6'b100110;
	localparam logic [5:0] fnShr = 6'b000010;
	localparam logic [5:0] fnShl = 6'b000000;

	typedef struct packed {
		logic [warpCnt-1:0] warpMask; // One-hot, zero when empty
		logic [31:0] pcPlus4;
		logic [31:0] instr;
	} fetchSlotT;

	typedef struct packed {
		logic [warpCnt-1:0] warpMask;
		logic [31:0] instr;
		logic [31:0] pcPlus4;
		logic [4:0] src1;
		logic [4:0] src2;
		logic [4:0] dst;
		logic [15:0] imm;
		logic src1Valid;
		logic src2Valid;
		logic immValid;
		logic regWrite;
		logic memWrite;
		logic memRead;
		logic sharedMem;
		logic exit;
		aluOpT aluOp;
		logic dotS;
		logic isBeq;
		logic isBlt;
		logic isCall;
		logic isRet;
		logic isJmp;
	} decodedT;

	typedef struct packed {
		logic [warpCnt-1:0] warpMask;
		logic [31:0] target; // Word address, not shifted
	} redirectT;

	typedef struct packed {
		logic [warpCnt-1:0] warpMask;
		logic [31:0] pcPlus4;
		logic dotS;
		logic isBeq;
		logic isBlt;
		logic isCall;
		logic isRet;
		logic isJmp;
	} simtEventT;

endpackage

//--- logic/instrBuffer.sv
`timescale 1ns/1ps

module instrBuffer import gpuDecodePkg::*; #(
	parameter int numWarps = 8,
	parameter int numLanes = 2
) (
	input logic clk,
	input logic rstN,
	input decodedT [numLanes-1:0] dec,
	input logic issueValid,
	input logic [$clog2(numWarps)-1:0] issueWarp,
	output decodedT issued,
	output logic issuedValid,
	output logic [numWarps-1:0] occupied
);

	decodedT entries [numWarps]; // One slot per warp
	logic [numWarps-1:0] writeMask;
	logic [numWarps-1:0] issueFree;

	always_comb begin
		writeMask = '0;
		for (int l = 0; l < numLanes; l++) begin
			writeMask = writeMask | dec[l].warpMask[numWarps-1:0];
		end
	end

	always_comb begin
		issueFree = '0;
		if (issueValid) begin
			issueFree[issueWarp] = 1'b1;
		end
	end

	// Each lane fills the slot its one-hot mask points at
	always_ff @(posedge clk) begin
		for (int l = 0; l < numLanes; l++) begin
			for (int w = 0; w < numWarps; w++) begin
				if (dec[l].warpMask[w]) begin
					entries[w] <= dec[l];
				end
			end
		end
	end

	// Issue reads the entry held before this edge
	always_ff @(posedge clk) begin
		if (issueValid) begin
			issued <= entries[issueWarp];
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			occupied <= '0;
			issuedValid <= 1'b0;
		end else begin
			occupied <= (occupied & ~issueFree) | writeMask; // New write wins over free
			issuedValid <= issueValid && occupied[issueWarp];
		end
	end

	// Fetch has no back-pressure, so it must not overwrite a waiting entry
	aNoOverwrite: assert property (
		@(posedge clk) disable iff (!rstN)
		(writeMask & occupied & ~issueFree) == '0
	) else $error("instrBuffer: write to occupied warp slot %b", writeMask & occupied);

endmodule

//--- logic/laneDecoder.sv
`timescale 1ns/1ps

module laneDecoder import gpuDecodePkg::*; (
	input fetchSlotT slot,
	output decodedT dec
);

	logic [5:0] opcode;
	logic [5:0] baseOp;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [15:0] imm;
	logic [5:0] funct;
	logic isInt;
	logic isAddi;
	logic isAndi;
	logic isOri;
	logic isXori;
	logic isLd;
	logic isLds;
	logic isSw;
	logic isSws;
	logic isBeq;
	logic isBlt;
	logic isLoad;
	logic isStore;
	logic isImmAlu;
	aluOpT immAluOp;
	aluOpT functAluOp;

	assign opcode = slot.instr[31:26];
	assign rs = slot.instr[25:21];
	assign rt = slot.instr[20:16];
	assign rd = slot.instr[15:11];
	assign imm = slot.instr[15:0];
	assign funct = slot.instr[5:0];

	// Fold each .S twin onto its base opcode
	assign baseOp = {opcode[5], 1'b0, opcode[3:0]};

	assign isInt = (baseOp == opInt);
	assign isAddi = (baseOp == opAddi);
	assign isAndi = (baseOp == opAndi);
	assign isOri = (baseOp == opOri);
	assign isXori = (baseOp == opXori);
	assign isLd = (baseOp == opLd);
	assign isLds = (baseOp == opLds);
	assign isSw = (baseOp == opSw);
	assign isSws = (baseOp == opSws);
	assign isBeq = (baseOp == opBeq);
	assign isBlt = (baseOp == opBlt);

	assign isLoad = isLd || isLds;
	assign isStore = isSw || isSws;
	assign isImmAlu = isAddi || isAndi || isOri || isXori;

	always_comb begin
		case (baseOp)
			opAndi: immAluOp = aluAnd;
			opOri: immAluOp = aluOr;
			opXori: immAluOp = aluXor;
			default: immAluOp = aluAdd; // ADDI
		endcase
	end

	always_comb begin
		case (funct)
			fnSub: functAluOp = aluSub;
			fnMul: functAluOp = aluMul;
			fnAnd: functAluOp = aluAnd;
			fnOr: functAluOp = aluOr;
			fnXor: functAluOp = aluXor;
			fnShr: functAluOp = aluShr;
			fnShl: functAluOp = aluShl;
			default: functAluOp = aluAdd; // ADD and unknown funct
		endcase
	end

	assign dec.warpMask = slot.warpMask;
	assign dec.instr = slot.instr;
	assign dec.pcPlus4 = slot.pcPlus4;
	assign dec.src1 = rs;
	assign dec.src2 = rt;
	assign dec.dst = (isLoad || isImmAlu) ? rt : rd; // I-type writes rt
	assign dec.imm = imm;

	assign dec.src1Valid = isInt || isImmAlu || isLoad || isStore || isBeq || isBlt;
	assign dec.src2Valid = isInt || isStore || isBeq || isBlt;
	assign dec.immValid = isImmAlu;

	assign dec.regWrite = isInt || isImmAlu || isLoad;
	assign dec.memWrite = isStore;
	assign dec.memRead = isLoad;
	assign dec.sharedMem = isLds || isSws;
	assign dec.exit = (baseOp == opExit);
	assign dec.aluOp = isImmAlu ? immAluOp : functAluOp;

	// Control-flow kinds for the SIMT stack and the PC path
	assign dec.dotS = opcode[dotSBit];
	assign dec.isBeq = isBeq;
	assign dec.isBlt = isBlt;
	assign dec.isCall = (baseOp == opCall);
	assign dec.isRet = (baseOp == opRet);
	assign dec.isJmp = (baseOp == opJ);

endmodule

//--- logic/pcRedirect.sv
`timescale 1ns/1ps

module pcRedirect import gpuDecodePkg::*; #(
	parameter int numLanes = 2
) (
	input logic clk,
	input logic rstN,
	input decodedT [numLanes-1:0] dec,
	output redirectT [numLanes-1:0] redirect,
	output simtEventT [numLanes-1:0] simtEvent
);

	logic [numLanes-1:0] takesPc;
	logic [numLanes-1:0] hasEvent;

	always_comb begin
		for (int l = 0; l < numLanes; l++) begin
			takesPc[l] = dec[l].isCall || dec[l].isJmp; // Only these move the PC here
			hasEvent[l] = dec[l].isBeq || dec[l].isBlt || dec[l].isCall
				|| dec[l].isRet || dec[l].isJmp;
		end
	end

	always_ff @(posedge clk) begin
		for (int l = 0; l < numLanes; l++) begin
			if (!rstN) begin
				redirect[l].warpMask <= '0;
				simtEvent[l].warpMask <= '0;
			end else begin
				redirect[l].warpMask <= takesPc[l] ? dec[l].warpMask : '0;
				simtEvent[l].warpMask <= hasEvent[l] ? dec[l].warpMask : '0;
			end
			redirect[l].target <= {6'b0, dec[l].instr[25:0]};
			simtEvent[l].pcPlus4 <= dec[l].pcPlus4;
			simtEvent[l].dotS <= dec[l].dotS;
			simtEvent[l].isBeq <= dec[l].isBeq;
			simtEvent[l].isBlt <= dec[l].isBlt;
			simtEvent[l].isCall <= dec[l].isCall;
			simtEvent[l].isRet <= dec[l].isRet;
			simtEvent[l].isJmp <= dec[l].isJmp;
		end
	end

	// Two lanes never decode the same warp
	for (genvar a = 0; a < numLanes; a++) begin : gLaneA
		for (genvar b = a + 1; b < numLanes; b++) begin : gLaneB
			aNoLaneConflict: assert property (
				@(posedge clk) disable iff (!rstN)
				(dec[a].warpMask & dec[b].warpMask) == '0
			) else $error("pcRedirect: lanes %0d and %0d share a warp", a, b);
		end
	end

endmodule

//--- runSim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f \
	--top-module decodeStageTb -Mdir obj_dir -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
	exit 0
fi
exit 1

//--- verification/decodeStageTb.sv
`timescale 1ns/1ps

module decodeStageTb import gpuDecodePkg::*; ();

	localparam int numWarps = 8;
	localparam int numLanes = 2;

	logic clk;
	logic rstN;
	fetchSlotT [numLanes-1:0] fetchIn;
	logic issueValid;
	logic [$clog2(numWarps)-1:0] issueWarp;
	redirectT [numLanes-1:0] redirect;
	simtEventT [numLanes-1:0] simtEvent;
	decodedT issued;
	logic issuedValid;
	logic [numWarps-1:0] occupied;

	int mismatches = 0;
	int otherErrors = 0;
	int cycles = 0;
	int cycleLimit = 0;
	string lines[$];
	redirectT pipe1R [numLanes];
	redirectT pipe2R [numLanes];
	simtEventT pipe1S [numLanes];
	simtEventT pipe2S [numLanes];
	logic [31:0] slotInstr [numWarps];
	logic [31:0] slotPc [numWarps];
	logic pendingIssue;
	logic expIssuedValid;
	decodedT expIssued;

	decodeStage #(.numWarps(numWarps), .numLanes(numLanes)) decodeStage_inst (
		.clk(clk), .rstN(rstN), .fetchIn(fetchIn), .issueValid(issueValid),
		.issueWarp(issueWarp), .redirect(redirect), .simtEvent(simtEvent),
		.issued(issued), .issuedValid(issuedValid), .occupied(occupied)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles > cycleLimit) begin
			$display("Timeout: run passed the limit of %0d cycles", cycleLimit);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic simtEventT expectEvent(logic [warpCnt-1:0] mask, logic [31:0] instr,
			logic [31:0] pc);
		simtEventT e;
		logic [5:0] op;
		op = instr[31:26];
		op[4] = 1'b0; // .S twins share the base kind
		e.pcPlus4 = pc;
		e.dotS = instr[30];
		e.isBeq = (op == opBeq);
		e.isBlt = (op == opBlt);
		e.isCall = (op == opCall);
		e.isRet = (op == opRet);
		e.isJmp = (op == opJ);
		e.warpMask = (e.isBeq || e.isBlt || e.isCall || e.isRet || e.isJmp) ? mask : '0;
		return e;
	endfunction

	function automatic redirectT expectRedirect(logic [warpCnt-1:0] mask, logic [31:0] instr);
		simtEventT k;
		redirectT r;
		k = expectEvent(mask, instr, '0);
		r.warpMask = (k.isCall || k.isJmp) ? mask : '0;
		r.target = {6'b0, instr[25:0]}; // Zero-extended jump field
		return r;
	endfunction

	task automatic checkDecoded(string name, decodedT exp, decodedT act);
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic checkRedirect(string name, redirectT exp, redirectT act);
		if ((exp.warpMask == '0) ? (act.warpMask !== '0) : (act !== exp)) begin
			mismatches++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic checkSimt(string name, simtEventT exp, simtEventT act);
		if ((exp.warpMask == '0) ? (act.warpMask !== '0) : (act !== exp)) begin
			mismatches++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic checkMask(string name, logic [numWarps-1:0] exp, logic [numWarps-1:0] act);
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic checkValid(string name, logic exp, logic act);
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic driveIdle();
		fetchIn = '0;
		issueValid = 1'b0;
		issueWarp = '0;
	endtask

	// Redirect and events trail their fetch by two edges
	task automatic checkCycle();
		for (int l = 0; l < numLanes; l++) begin
			checkRedirect($sformatf("redirect[%0d]", l), pipe2R[l], redirect[l]);
			checkSimt($sformatf("simtEvent[%0d]", l), pipe2S[l], simtEvent[l]);
			pipe2R[l] = pipe1R[l];
			pipe2S[l] = pipe1S[l];
			pipe1R[l] = '0;
			pipe1S[l] = '0;
		end
		checkValid("issuedValid", pendingIssue && expIssuedValid, issuedValid);
		if (pendingIssue && expIssuedValid) checkDecoded("issued", expIssued, issued);
		pendingIssue = 1'b0;
	endtask

	task automatic checkIdle();
		checkMask("occupied", '0, occupied);
		checkValid("issuedValid", 1'b0, issuedValid);
		for (int l = 0; l < numLanes; l++) begin
			checkRedirect($sformatf("redirect[%0d]", l), '0, redirect[l]);
			checkSimt($sformatf("simtEvent[%0d]", l), '0, simtEvent[l]);
			pipe1R[l] = '0;
			pipe2R[l] = '0;
			pipe1S[l] = '0;
			pipe2S[l] = '0;
		end
		pendingIssue = 1'b0;
	endtask

	task automatic applyReset();
		driveIdle();
		rstN = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		checkIdle();
		rstN = 1'b1;
	endtask

	task automatic driveSlot(int lane, int w, logic [31:0] instr, logic [31:0] pc);
		logic [warpCnt-1:0] mask;
		mask = '0;
		if (w < numWarps) begin
			mask[w] = 1'b1;
			slotInstr[w] = instr;
			slotPc[w] = pc;
		end
		fetchIn[lane].warpMask = mask;
		fetchIn[lane].instr = instr;
		fetchIn[lane].pcPlus4 = pc;
		pipe1R[lane] = expectRedirect(mask, instr);
		pipe1S[lane] = expectEvent(mask, instr, pc);
	endtask

	// f holds warp, valid, aluOp, then the flags and dst in file column order
	task automatic driveIssue(logic [31:0] f [13]);
		int w;
		decodedT e;
		simtEventT k;
		w = int'(f[0]);
		k = expectEvent('0, slotInstr[w], slotPc[w]);
		e = '0;
		e.warpMask[w] = 1'b1;
		e.instr = slotInstr[w];
		e.pcPlus4 = slotPc[w];
		e.src1 = slotInstr[w][25:21];
		e.src2 = slotInstr[w][20:16];
		e.imm = slotInstr[w][15:0];
		e.aluOp = aluOpT'(f[2][3:0]);
		e.regWrite = f[3] != 0;
		e.memRead = f[4] != 0;
		e.memWrite = f[5] != 0;
		e.sharedMem = f[6] != 0;
		e.src1Valid = f[7] != 0;
		e.src2Valid = f[8] != 0;
		e.immValid = f[9] != 0;
		e.dst = f[10][4:0];
		e.dotS = f[11] != 0;
		e.exit = f[12] != 0;
		e.isBeq = k.isBeq;
		e.isBlt = k.isBlt;
		e.isCall = k.isCall;
		e.isRet = k.isRet;
		e.isJmp = k.isJmp;
		issueValid = 1'b1;
		issueWarp = w[$clog2(numWarps)-1:0];
		pendingIssue = 1'b1;
		expIssuedValid = f[1] != 0;
		expIssued = e;
	endtask

	initial begin
		int fd;
		string line;
		string kind;
		logic [31:0] a [6];
		logic [31:0] f [13];
		rstN = 1'b0;
		driveIdle();
		pendingIssue = 1'b0;
		for (int w = 0; w < numWarps; w++) begin
			slotInstr[w] = '0;
			slotPc[w] = '0;
		end
		fd = $fopen("verification/decodeTests.txt", "r");
		if (fd == 0) begin
			otherErrors++;
			$display("Could not open the test file verification/decodeTests.txt");
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0 && $sscanf(line, "%s", kind) == 1
						&& kind.getc(0) != "#") lines.push_back(line);
			end
			$fclose(fd);
		end
		cycleLimit = 4 * lines.size() + 50;
		applyReset();
		foreach (lines[n]) begin
			@(posedge clk);
			#1;
			checkCycle();
			driveIdle();
			void'($sscanf(lines[n], "%s", kind));
			if (kind == "F" && $sscanf(lines[n], "%s %h %h %h %h %h %h", kind,
					a[0], a[1], a[2], a[3], a[4], a[5]) == 7) begin
				driveSlot(0, int'(a[0]), a[1], a[2]);
				driveSlot(1, int'(a[3]), a[4], a[5]);
			end else if (kind == "I" && $sscanf(lines[n],
					"%s %h %h %h %h %h %h %h %h %h %h %h %h %h", kind, f[0], f[1], f[2],
					f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]) == 14) begin
				driveIssue(f);
			end else if (kind == "O" && $sscanf(lines[n], "%s %h", kind, a[0]) == 2) begin
				checkMask("occupied", a[0][numWarps-1:0], occupied);
			end else if (kind == "R") begin
				applyReset();
			end else if (kind != "N") begin
				otherErrors++;
				$display("Test line %0d could not be read: %s", n, lines[n]);
			end
		end
		repeat (3) begin
			@(posedge clk);
			#1;
			checkCycle();
			driveIdle();
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
		if (mismatches == 0 && otherErrors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- verification/decodeTests.txt
# F lane0Warp lane0Instr lane0PcPlus4 lane1Warp lane1Instr lane1PcPlus4 (warp 8 = no warp)
# I warp valid aluOp regWrite memRead memWrite sharedMem src1V src2V immV dst dotS exit
# O occupiedMask | N idle cycle | R reset
F 0 00221820 00000104 1 00221822 00000108
F 2 00221818 0000010c 3 00221824 00000110
F 4 00221825 00000114 5 00221826 00000118
F 6 00221802 0000011c 7 00221800 00000120
N
O ff
I 0 1 0 1 0 0 0 1 1 0 3 0 0
I 1 1 1 1 0 0 0 1 1 0 3 0 0
I 2 1 2 1 0 0 0 1 1 0 3 0 0
I 3 1 3 1 0 0 0 1 1 0 3 0 0
I 4 1 4 1 0 0 0 1 1 0 3 0 0
I 5 1 5 1 0 0 0 1 1 0 3 0 0
I 6 1 6 1 0 0 0 1 1 0 3 0 0
I 7 1 7 1 0 0 0 1 1 0 3 0 0
O 00
F 0 0022183f 00000204 1 20220010 00000208
F 2 30220010 0000020c 3 34220010 00000210
F 4 38220010 00000214 5 60220010 00000218
F 6 70220010 0000021c 7 74220010 00000220
N
O ff
I 0 1 0 1 0 0 0 1 1 0 3 0 0
I 1 1 0 1 0 0 0 1 0 1 2 0 0
I 2 1 3 1 0 0 0 1 0 1 2 0 0
I 3 1 4 1 0 0 0 1 0 1 2 0 0
I 4 1 5 1 0 0 0 1 0 1 2 0 0
I 5 1 0 1 0 0 0 1 0 1 2 1 0
I 6 1 3 1 0 0 0 1 0 1 2 1 0
I 7 1 4 1 0 0 0 1 0 1 2 1 0
O 00
F 0 78220010 00000304 1 8c220010 00000308
F 2 9c220010 0000030c 3 ac220010 00000310
F 4 bc220010 00000314 5 50220008 00000318
N
O 3f
I 0 1 5 1 0 0 0 1 0 1 2 1 0
I 1 1 0 1 1 0 0 1 0 0 2 0 0
I 2 1 0 1 1 0 1 1 0 0 2 0 0
I 3 1 0 0 0 1 0 1 1 0 0 0 0
I 4 1 0 0 0 1 1 1 1 0 0 0 0
I 5 1 0 0 0 0 0 1 1 0 0 1 0
I 7 0 0 0 0 0 0 0 0 0 0 0 0
O 00
F 0 08000040 00000404 1 0c000080 00000408
F 2 18000000 0000040c 3 10220008 00000410
F 4 1c220008 00000414 5 84000000 00000418
N
O 3f
I 0 1 7 0 0 0 0 0 0 0 0 0 0
I 1 1 7 0 0 0 0 0 0 0 0 0 0
I 2 1 7 0 0 0 0 0 0 0 0 0 0
I 3 1 0 0 0 0 0 1 1 0 0 0 0
I 4 1 0 0 0 0 0 1 1 0 0 0 0
I 5 1 7 0 0 0 0 0 0 0 0 0 1
O 00
F 0 00221820 00000504 1 08000040 00000508
R
O 00

//--- vlog.f
logic/gpuDecodePkg.sv
logic/fetchLatch.sv
logic/laneDecoder.sv
logic/pcRedirect.sv
logic/instrBuffer.sv
logic/decodeStage.sv
verification/decodeStageTb.sv
